// ==== logic/synth_pkg.sv ====
// shared widths, structs, state enums and the envelope gain table, imported by design and testbench
`default_nettype none

package synth_pkg;

    localparam int sample_w    = 8;
    localparam int frame_w     = 32;
    localparam int voice_count = 3;
    localparam int lead_bits   = 4;   // zero control bits ahead of the DAC data

    localparam logic [frame_w-1:0] sync_word = 32'h0000_FFFF;

    typedef logic [sample_w-1:0] sample_t;
    typedef logic [8:0]          gain_t;   // units of 1/256 with 256 as full level

    // serial word layout with msb first on the wire
    typedef struct packed {
        logic [5:0] reserved;
        logic [1:0] notes_count;
        sample_t    note3;
        sample_t    note2;
        sample_t    note1;
    } note_frame_t;

    typedef struct packed {
        logic active;
        logic done;
    } voice_status_t;

    typedef enum logic [2:0] {
        env_idle,
        env_attack,
        env_peak,
        env_decay,
        env_sustain,
        env_release,
        env_done
    } env_phase_t;

    typedef enum logic [1:0] {
        dac_lead,
        dac_data,
        dac_load,
        dac_latch
    } dac_state_t;

    function automatic gain_t phase_gain(env_phase_t phase);
        case (phase)
            env_attack:  return 9'd128;
            env_peak:    return 9'd256;
            env_decay:   return 9'd192;
            env_sustain: return 9'd160;
            env_release: return 9'd64;
            default:     return 9'd0;   // idle and done are silent
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== logic/spi_note_receiver.sv ====
// receive-only serial input that locks on the sync word and hands note frames to the top level
`timescale 1ns/10ps
`default_nettype none

module spi_note_receiver
    import synth_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        sck,
    input  wire logic        sdi,
    output note_frame_t      frame,
    output logic             frame_strobe
);

    localparam int cnt_w = $clog2(frame_w);

    logic               sck_meta, sck_sync, sck_prev;
    logic               sdi_meta, sdi_sync;
    logic               sck_rise;
    logic [frame_w-1:0] shift_reg;
    logic [frame_w-1:0] shift_next;
    logic               locked;
    logic [cnt_w-1:0]   bit_cnt;

    assign sck_rise   = sck_sync & ~sck_prev;
    assign shift_next = {shift_reg[frame_w-2:0], sdi_sync};

    // two-flop synchronisers plus edge history
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            sck_meta <= 1'b0;
            sck_sync <= 1'b0;
            sck_prev <= 1'b0;
            sdi_meta <= 1'b0;
            sdi_sync <= 1'b0;
        end
        else
        begin
            sck_meta <= sck;
            sck_sync <= sck_meta;
            sck_prev <= sck_sync;
            sdi_meta <= sdi;
            sdi_sync <= sdi_meta;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            shift_reg    <= '0;
            locked       <= 1'b0;
            bit_cnt      <= '0;
            frame        <= '0;
            frame_strobe <= 1'b0;
        end
        else
        begin
            frame_strobe <= 1'b0;
            if (sck_rise)
            begin
                shift_reg <= shift_next;
                if (!locked)
                begin
                    if (shift_next == sync_word)
                    begin
                        locked  <= 1'b1;   // no relock after this
                        bit_cnt <= '0;
                    end
                end
                else
                begin
                    bit_cnt <= bit_cnt + 1'b1;   // wraps every word
                    if (bit_cnt == cnt_w'(frame_w - 1))
                    begin
                        frame        <= note_frame_t'(shift_next);
                        frame_strobe <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/note_envelope.sv ====
// per-voice struck-key envelope, one instance per voice in the top level
`timescale 1ns/10ps
`default_nettype none

module note_envelope
    import synth_pkg::*;
#(
    parameter int phase_cycles = 750000
) (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire sample_t note,
    output sample_t      level,
    output voice_status_t status
);

    localparam int timer_w = $clog2(phase_cycles + 1);

    env_phase_t         phase;
    logic [timer_w-1:0] timer;
    logic [16:0]        product;

    // order of the timed phases
    function automatic env_phase_t next_phase(env_phase_t cur);
        case (cur)
            env_attack:  return env_peak;
            env_peak:    return env_decay;
            env_decay:   return env_sustain;
            env_sustain: return env_release;
            default:     return env_done;
        endcase
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            phase <= env_idle;
            timer <= '0;
        end
        else if (note == '0)
        begin
            phase <= env_idle;   // key released so the next note restarts
            timer <= '0;
        end
        else
        begin
            case (phase)
                env_idle:
                begin
                    phase <= env_attack;
                    timer <= '0;
                end
                env_done:
                begin
                    phase <= env_done;   // hold until the note clears
                end
                default:
                begin
                    if (timer == timer_w'(phase_cycles - 1))
                    begin
                        timer <= '0;
                        phase <= next_phase(phase);
                    end
                    else
                    begin
                        timer <= timer + 1'b1;
                    end
                end
            endcase
        end
    end

    assign product = note * phase_gain(phase);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            level <= '0;
        else
            level <= sample_t'(product >> 8);   // gain is in 1/256 steps
    end

    assign status.active = (phase != env_idle) && (phase != env_done);
    assign status.done   = (phase == env_done);

endmodule

`default_nettype wire

// ==== logic/voice_mixer.sv ====
// mixer that sums the sounding voices and normalises by their count for the DAC side
`timescale 1ns/10ps
`default_nettype none

module voice_mixer
    import synth_pkg::*;
(
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire sample_t       [voice_count-1:0] levels,
    input  wire voice_status_t [voice_count-1:0] status,
    input  wire logic     [1:0]               notes_count,
    output sample_t                           mix
);

    logic [voice_count-1:0] incl;
    logic [9:0]             sum;
    logic [1:0]             n;
    logic [9:0]             quot;

    // voice i+1 counts only if it is held and sounding
    always_comb
    begin
        for (int i = 0; i < voice_count; i++)
            incl[i] = (2'(i + 1) <= notes_count) && status[i].active;
    end

    always_comb
    begin
        sum = '0;
        n   = '0;
        for (int i = 0; i < voice_count; i++)
        begin
            if (incl[i])
            begin
                sum = sum + 10'(levels[i]);
                n   = n + 2'd1;
            end
        end
    end

    always_comb
    begin
        case (n)
            2'd1:    quot = sum;
            2'd2:    quot = sum >> 1;
            2'd3:    quot = (sum >> 2) + (sum >> 4) + (sum >> 6) + (sum >> 8); // close to /3
            default: quot = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            mix <= '0;
        else
            mix <= sample_t'(quot);
    end

endmodule

`default_nettype wire

// ==== logic/dac_serializer.sv ====
// serial DAC output that sends one mixed sample per frame of lead, data, load and latch periods
`timescale 1ns/10ps
`default_nettype none

module dac_serializer
    import synth_pkg::*;
#(
    parameter int bit_cycles = 40
) (
    input  wire logic    clk,
    input  wire logic    rst_n,
    input  wire sample_t sample,
    output logic         dclk,
    output logic         data,
    output logic         load,
    output logic         ldac
);

    localparam int cyc_w = $clog2(bit_cycles);
    localparam int idx_w = $clog2(sample_w);

    dac_state_t       state;
    logic [cyc_w-1:0] cyc;       // position inside the bit period
    logic [idx_w-1:0] bit_idx;   // bit within lead or data
    sample_t          shreg;
    logic             period_end;
    logic             period_start;

    assign period_end   = (cyc == cyc_w'(bit_cycles - 1));
    assign period_start = (cyc == '0);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state   <= dac_lead;
            cyc     <= '0;
            bit_idx <= '0;
        end
        else if (period_end)
        begin
            cyc <= '0;
            case (state)
                dac_lead:
                begin
                    if (bit_idx == idx_w'(lead_bits - 1))
                    begin
                        state   <= dac_data;
                        bit_idx <= '0;
                    end
                    else
                        bit_idx <= bit_idx + 1'b1;
                end
                dac_data:
                begin
                    if (bit_idx == idx_w'(sample_w - 1))
                    begin
                        state   <= dac_load;
                        bit_idx <= '0;
                    end
                    else
                        bit_idx <= bit_idx + 1'b1;
                end
                dac_load:  state <= dac_latch;
                default:   state <= dac_lead;   // latch ends the frame
            endcase
        end
        else
        begin
            cyc <= cyc + 1'b1;
        end
    end

    // newest mix is taken at the very start of each frame
    always_ff @(posedge clk)
    begin
        if (state == dac_lead && bit_idx == '0 && period_start)
            shreg <= sample;
        else if (state == dac_data && period_start)
            shreg <= {shreg[sample_w-2:0], 1'b0};
    end

    // outputs run one cycle behind the counters
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            dclk <= 1'b0;
            data <= 1'b0;
            load <= 1'b1;
            ldac <= 1'b1;
        end
        else
        begin
            dclk <= (state == dac_lead || state == dac_data) &&
                    (cyc < cyc_w'(bit_cycles / 2));
            load <= (state != dac_load);
            ldac <= (state != dac_latch);
            if (state == dac_data)
            begin
                if (period_start)
                    data <= shreg[sample_w-1];   // msb first
            end
            else
                data <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/piano_synth.sv ====
// top level of the three-voice tone generator that takes serial note words and drives a serial DAC
`timescale 1ns/10ps
`default_nettype none

module piano_synth
    import synth_pkg::*;
#(
    parameter int phase_cycles = 750000,
    parameter int bit_cycles   = 40
) (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic       sck,
    input  wire logic       sdi,
    output logic [5:0]      led,
    output logic            dclk,
    output logic            data,
    output logic            load,
    output logic            ldac
);

    note_frame_t                      frame;
    sample_t       [voice_count-1:0]  notes;
    sample_t       [voice_count-1:0]  levels;
    voice_status_t [voice_count-1:0]  status;
    sample_t                          mix;

    spi_note_receiver u_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .sck          (sck),
        .sdi          (sdi),
        .frame        (frame),
        .frame_strobe ()
    );

    assign notes = {frame.note3, frame.note2, frame.note1};

    for (genvar g = 0; g < voice_count; g++)
    begin : g_voice
        note_envelope #(
            .phase_cycles (phase_cycles)
        ) u_env (
            .clk    (clk),
            .rst_n  (rst_n),
            .note   (notes[g]),
            .level  (levels[g]),
            .status (status[g])
        );
    end

    voice_mixer u_mix (
        .clk         (clk),
        .rst_n       (rst_n),
        .levels      (levels),
        .status      (status),
        .notes_count (frame.notes_count),
        .mix         (mix)
    );

    dac_serializer #(
        .bit_cycles (bit_cycles)
    ) u_dac (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (mix),
        .dclk   (dclk),
        .data   (data),
        .load   (load),
        .ldac   (ldac)
    );

    assign led = {status[0], status[1], status[2]};   // voice 1 in the top pair

endmodule

`default_nettype wire

// ==== tests/dac_frame_sva.sv ====
// DAC framing assertions bound into every dac_serializer instance
`timescale 1ns/10ps
`default_nettype none

module dac_frame_sva #(
    parameter int bit_cycles = 40
) (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic dclk,
    input wire logic load,
    input wire logic ldac
);

    int low_len;          // consecutive cycles with load low
    int fail_count = 0;   // failed assertion count

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            low_len <= 0;
        else if (!load)
            low_len <= low_len + 1;
        else
            low_len <= 0;
    end

    a_strobes_apart: assert property (@(posedge clk) disable iff (!rst_n) load || ldac)
    else
    begin
        $error("load and ldac are low together");
        fail_count++;
    end

    // no bit clock while a strobe is out
    a_dclk_quiet: assert property (@(posedge clk) disable iff (!rst_n) (!load || !ldac) |-> !dclk)
    else
    begin
        $error("dclk high during a load or ldac strobe");
        fail_count++;
    end

    a_load_width: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(load) |-> (low_len == bit_cycles))
    else
    begin
        $error("load low pulse lasted %0d cycles", low_len);
        fail_count++;
    end

endmodule

bind dac_serializer dac_frame_sva #(
    .bit_cycles (bit_cycles)
) u_frame_sva (
    .clk   (clk),
    .rst_n (rst_n),
    .dclk  (dclk),
    .load  (load),
    .ldac  (ldac)
);

`default_nettype wire

// ==== tests/piano_synth_tb.sv ====
// simulation top that sends note words to the tone generator and decodes its serial DAC stream
`timescale 1ns/10ps
`default_nettype none

module piano_synth_tb
    import synth_pkg::*;
();

    localparam int phase_cycles = 300;
    localparam int bit_cycles   = 8;
    localparam int clk_period   = 20;
    localparam int drive_delay  = 2;
    localparam int sck_half     = 4;   // clk cycles per sck level
    localparam int phase_count  = 5;   // attack through release
    localparam int test_count   = 6;
    localparam int frame_cycles = (lead_bits + sample_w + 2) * bit_cycles;
    localparam longint watchdog_ns =
        longint'(8 * test_count * phase_cycles * clk_period) + 40000;

    logic       clk;
    logic       rst_n;
    logic       sck;
    logic       sdi;
    logic [5:0] led;
    logic       dclk;
    logic       data;
    logic       load;
    logic       ldac;

    logic [31:0] rng_state;
    int          dac_samples[$];   // decoded DAC words in arrival order
    int          rd_idx;
    logic [11:0] dac_bits;
    int          dac_bit_cnt;
    int          gain_table[phase_count] = '{128, 256, 192, 160, 64};

    piano_synth #(
        .phase_cycles (phase_cycles),
        .bit_cycles   (bit_cycles)
    ) dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .sck   (sck),
        .sdi   (sdi),
        .led   (led),
        .dclk  (dclk),
        .data  (data),
        .load  (load),
        .ldac  (ldac)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    task automatic stop_failed();
        $display("Done: errors found");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            stop_failed();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // kept well above zero so every phase level stays distinct
    function automatic int random_note();
        rng_state = xorshift32(rng_state);
        return 64 + int'(rng_state % 192);
    endfunction

    function automatic int voice_level(input int note, input int phase);
        return (note * gain_table[phase]) / 256;
    endfunction

    function automatic int mix_rule(input int sum, input int n);
        case (n)
            1:       return sum;
            2:       return sum / 2;
            3:       return sum / 4 + sum / 16 + sum / 64 + sum / 256;
            default: return 0;
        endcase
    endfunction

    function automatic logic [31:0] make_word(input int count, input int n1,
                                              input int n2, input int n3);
        note_frame_t f;
        f             = '0;
        f.notes_count = 2'(count);
        f.note1       = sample_t'(n1);
        f.note2       = sample_t'(n2);
        f.note3       = sample_t'(n3);
        return f;
    endfunction

    task automatic send_word(input logic [31:0] word);
        for (int i = frame_w - 1; i >= 0; i--)
        begin
            @(posedge clk);
            #drive_delay;
            sck = 1'b0;
            sdi = word[i];   // settles a full low phase before the edge
            repeat (sck_half) @(posedge clk);
            #drive_delay;
            sck = 1'b1;
            repeat (sck_half - 1) @(posedge clk);
        end
    endtask

    // decoder takes one bit per falling dclk and a word per ldac strobe
    always @(negedge dclk)
    begin
        if (rst_n === 1'b1)
        begin
            dac_bits    = {dac_bits[10:0], data};
            dac_bit_cnt = dac_bit_cnt + 1;
        end
    end

    always @(negedge ldac)
    begin
        if (rst_n === 1'b1)
        begin
            check_value("dac bits per frame", dac_bit_cnt, lead_bits + sample_w);
            check_value("dac lead bits", 32'(dac_bits[11:8]), 0);
            dac_samples.push_back(int'(dac_bits[7:0]));
        end
        dac_bit_cnt = 0;
    end

    always @(negedge clk)
    begin
        if (dut0.u_dac.u_frame_sva.fail_count != 0)
        begin
            $display("a DAC framing assertion failed");
            stop_failed();
        end
    end

    task automatic next_sample(output int s);
        while (dac_samples.size() <= rd_idx)
            @(negedge clk);
        s = dac_samples[rd_idx];
        rd_idx++;
    endtask

    task automatic wait_led(input logic [5:0] mask, input logic [5:0] value,
                            input int max_cycles, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while ((led & mask) !== value)
        begin
            if (n >= max_cycles)
            begin
                $display("timed out waiting for %s, led is %b", what, led);
                stop_failed();
            end
            n++;
            @(negedge clk);
        end
    endtask

    // send a zero frame and skip words captured before the silence
    task automatic go_silent();
        int s;
        send_word(make_word(0, 0, 0, 0));
        wait_led(6'h3f, 6'h00, 16, "all voices idle");
        rd_idx = dac_samples.size();
        next_sample(s);
        next_sample(s);
        check_value("silent mix", s, 0);
    endtask

    task automatic check_envelope(input int n1, input int n2, input int n3,
                                  input int voices, input int steps);
        int expected[$];
        int sum;
        int s;
        int last;
        int idx;
        for (int p = 0; p < phase_count; p++)
        begin
            sum = voice_level(n1, p);
            if (voices > 1)
                sum = sum + voice_level(n2, p);
            if (voices > 2)
                sum = sum + voice_level(n3, p);
            expected.push_back(mix_rule(sum, voices));
        end
        expected.push_back(0);   // every voice done
        last = 0;
        idx  = 0;
        while (idx < steps)
        begin
            next_sample(s);
            if (s != last)   // repeats collapse and leading silence drops out
            begin
                check_value("decoded sample", s, expected[idx]);
                last = s;
                idx++;
            end
        end
    endtask

    task automatic reset_silence();
        int s;
        @(negedge clk);
        check_value("load", 32'(load), 1);
        check_value("ldac", 32'(ldac), 1);
        check_value("led", 32'(led), 0);
        for (int i = 0; i < 3; i++)
        begin
            next_sample(s);
            check_value("decoded sample", s, 0);
        end
    endtask

    task automatic sync_lock();
        logic [31:0] word;
        int          s;
        word = make_word(1, 8'h90, 0, 0);
        send_word(word);   // receiver still unlocked
        repeat (2 * frame_cycles) @(negedge clk);
        check_value("led", 32'(led), 0);
        while (rd_idx < dac_samples.size())
        begin
            next_sample(s);
            check_value("decoded sample", s, 0);
        end
        send_word(sync_word);
        send_word(word);
        wait_led(6'b100000, 6'b100000, 16, "voice 1 active after sync");
    endtask

    task automatic voices_together(input int voices);
        int         n1;
        int         n2;
        int         n3;
        logic [5:0] exp_led;
        go_silent();
        n1 = random_note();
        n2 = (voices > 1) ? random_note() : 0;
        n3 = (voices > 2) ? random_note() : 0;
        send_word(make_word(voices, n1, n2, n3));
        check_envelope(n1, n2, n3, voices, phase_count + 1);
        exp_led = 6'b010000 | ((voices > 1) ? 6'b000100 : 6'b0) |
                  ((voices > 2) ? 6'b000001 : 6'b0);
        @(negedge clk);
        check_value("led", 32'(led), 32'(exp_led));
    endtask

    task automatic count_mask_restart();
        int n1;
        int n2;
        go_silent();
        n1 = random_note();
        n2 = random_note();
        send_word(make_word(1, n1, n2, 0));   // voice 2 sounds but is not counted
        check_envelope(n1, n2, 0, 1, phase_count + 1);
        go_silent();
        send_word(make_word(1, n1, 0, 0));
        check_envelope(n1, 0, 0, 1, 1);
        @(negedge clk);
        check_value("led voice 1", 32'(led[5:4]), 32'(2'b10));
    endtask

    initial
    begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        stop_failed();
    end

    initial
    begin
        rst_n       = 1'b0;
        sck         = 1'b0;
        sdi         = 1'b0;
        rng_state   = 32'd80603;
        rd_idx      = 0;
        dac_bits    = '0;
        dac_bit_cnt = 0;
        repeat (8) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;

        reset_silence();
        sync_lock();
        voices_together(1);
        voices_together(2);
        voices_together(3);
        count_mask_restart();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== piano_synth.f ====
logic/synth_pkg.sv
logic/spi_note_receiver.sv
logic/note_envelope.sv
logic/voice_mixer.sv
logic/dac_serializer.sv
logic/piano_synth.sv
tests/dac_frame_sva.sv
tests/piano_synth_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= piano_synth_tb
FILELIST  ?= piano_synth.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
